// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // base opcodes of the kept instructions
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_op     = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_t;

    // funct3 in the low bits, funct7[5] on top
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b1000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_sra  = 4'b1101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111
    } alu_op_t;

    typedef enum logic [2:0] {
        imm_i       = 3'b000,
        imm_i_shamt = 3'b001,
        imm_s       = 3'b010,
        imm_b       = 3'b011,
        imm_j       = 3'b100,
        imm_u       = 3'b101
    } imm_type_t;

    // load funct3 values; stores reuse the low three for their width
    typedef enum logic [2:0] {
        ld_byte   = 3'b000,
        ld_half   = 3'b001,
        ld_word   = 3'b010,
        ld_byte_u = 3'b100,
        ld_half_u = 3'b101
    } load_type_t;

    typedef enum logic [1:0] {
        wb_alu       = 2'b00,
        wb_load      = 2'b01,
        wb_pc_plus_4 = 2'b10,
        wb_imm       = 2'b11
    } wb_sel_t;

    typedef enum logic [1:0] {
        pc_sel_plus_4 = 2'b00,
        pc_sel_target = 2'b01,
        pc_sel_jalr   = 2'b10
    } pc_sel_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       src_1_pc;
        logic       src_2_imm;
        imm_type_t  imm_type;
        wb_sel_t    wb_sel;
        logic       rf_wr_en;
        pc_sel_t    pc_sel;
        load_type_t load_type;
        logic       store_en;
    } ctrl_t;

endpackage

// ==== src/rv_alu.sv ====
module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result,
    output logic            cmp_flag
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = word_t'($signed(a) < $signed(b));
            alu_sltu: result = word_t'(a < b);
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

    // equality for sub, less-than for the set ops
    always_comb begin
        case (op)
            alu_sub:  cmp_flag = (result == '0);
            alu_slt,
            alu_sltu: cmp_flag = result[0];
            default:  cmp_flag = 1'b0;
        endcase
    end

endmodule

// ==== src/rv_imm_gen.sv ====
module rv_imm_gen (
    input  rv_pkg::word_t     instr,
    input  rv_pkg::imm_type_t imm_type,
    output rv_pkg::word_t     imm
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_type)
            imm_i_shamt: imm = {27'b0, instr[24:20]};
            imm_s:       imm = {{20{sign}}, instr[31:25], instr[11:7]};
            imm_b:       imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            imm_j:       imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            imm_u:       imm = {instr[31:12], 12'b0};
            // plain i format
            default:     imm = {{20{sign}}, instr[31:20]};
        endcase
    end

endmodule

// ==== src/rv_regfile.sv ====
module rv_regfile (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              wr_en,
    input  rv_pkg::word_t     wr_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [num_regs];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    // x0 always reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_fetch.sv ====
module rv_fetch (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::pc_sel_t pc_sel,
    input  rv_pkg::word_t   imm,
    input  rv_pkg::word_t   alu_result,
    output rv_pkg::word_t   pc,
    output rv_pkg::word_t   pc_plus_4
);
    import rv_pkg::*;

    word_t pc_next;

    assign pc_plus_4 = pc + word_t'(4);

    always_comb begin
        case (pc_sel)
            pc_sel_target: pc_next = pc + imm;
            // jalr target drops bit 0
            pc_sel_jalr:   pc_next = {alu_result[xlen-1:1], 1'b0};
            default:       pc_next = pc_plus_4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// ==== src/rv_lsu.sv ====
module rv_lsu (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t rd_data,
    output rv_pkg::word_t load_data,
    output logic [3:0]    wr_en
);
    import rv_pkg::*;

    // load extension, half sign is bit 15
    always_comb begin
        case (ctrl.load_type)
            ld_byte:   load_data = {{24{rd_data[7]}}, rd_data[7:0]};
            ld_half:   load_data = {{16{rd_data[15]}}, rd_data[15:0]};
            ld_byte_u: load_data = {24'b0, rd_data[7:0]};
            ld_half_u: load_data = {16'b0, rd_data[15:0]};
            default:   load_data = rd_data;
        endcase
    end

    // store width comes through load_type
    always_comb begin
        if (!ctrl.store_en) begin
            wr_en = 4'b0000;
        end else begin
            case (ctrl.load_type)
                ld_byte: wr_en = 4'b0001;
                ld_half: wr_en = 4'b0011;
                default: wr_en = 4'b1111;
            endcase
        end
    end

endmodule

// ==== src/rv_decoder.sv ====
module rv_decoder (
    input  logic          reset,
    input  rv_pkg::word_t instr,
    input  logic          cmp_flag,
    output rv_pkg::ctrl_t ctrl
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       funct7_zero;
    logic       funct7_alt;

    assign funct3      = instr[14:12];
    assign funct7      = instr[31:25];
    assign funct7_zero = (funct7 == 7'b0000000);
    assign funct7_alt  = (funct7 == 7'b0100000);

    always_comb begin
        // no-op unless a legal encoding overrides it
        ctrl.alu_op    = alu_add;
        ctrl.src_1_pc  = 1'b0;
        ctrl.src_2_imm = 1'b0;
        ctrl.imm_type  = imm_i;
        ctrl.wb_sel    = wb_alu;
        ctrl.rf_wr_en  = 1'b0;
        ctrl.pc_sel    = pc_sel_plus_4;
        ctrl.load_type = ld_word;
        ctrl.store_en  = 1'b0;

        if (!reset) begin
            case (opcode_t'(instr[6:0]))
                op_load: begin
                    if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                        ctrl.src_2_imm = 1'b1;
                        ctrl.wb_sel    = wb_load;
                        ctrl.rf_wr_en  = 1'b1;
                        ctrl.load_type = load_type_t'(funct3);
                    end
                end
                op_imm: begin
                    // shifts are the only immediates with funct7 bits
                    if ((funct3 != 3'b001 || funct7_zero) &&
                        (funct3 != 3'b101 || funct7_zero || funct7_alt)) begin
                        ctrl.alu_op    = alu_op_t'({funct3 == 3'b101 && funct7[5], funct3});
                        ctrl.src_2_imm = 1'b1;
                        ctrl.imm_type  = (funct3[1:0] == 2'b01) ? imm_i_shamt : imm_i;
                        ctrl.rf_wr_en  = 1'b1;
                    end
                end
                op_store: begin
                    if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
                        ctrl.src_2_imm = 1'b1;
                        ctrl.imm_type  = imm_s;
                        ctrl.load_type = load_type_t'(funct3);
                        ctrl.store_en  = 1'b1;
                    end
                end
                op_op: begin
                    // sub and sra are the only alt encodings
                    if (funct7_zero ||
                        (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                        ctrl.alu_op   = alu_op_t'({funct7[5], funct3});
                        ctrl.rf_wr_en = 1'b1;
                    end
                end
                op_branch: begin
                    if (funct3[2:1] != 2'b01) begin
                        // beq/bne use sub, blt/bge slt, bltu/bgeu sltu
                        ctrl.alu_op   = alu_op_t'({~funct3[2], 1'b0, funct3[2:1]});
                        ctrl.imm_type = imm_b;
                        ctrl.pc_sel   = (cmp_flag ^ funct3[0]) ? pc_sel_target : pc_sel_plus_4;
                    end
                end
                op_jal: begin
                    ctrl.imm_type = imm_j;
                    ctrl.wb_sel   = wb_pc_plus_4;
                    ctrl.rf_wr_en = 1'b1;
                    ctrl.pc_sel   = pc_sel_target;
                end
                op_jalr: begin
                    if (funct3 == 3'b000) begin
                        ctrl.src_2_imm = 1'b1;
                        ctrl.wb_sel    = wb_pc_plus_4;
                        ctrl.rf_wr_en  = 1'b1;
                        ctrl.pc_sel    = pc_sel_jalr;
                    end
                end
                op_lui: begin
                    ctrl.imm_type = imm_u;
                    ctrl.wb_sel   = wb_imm;
                    ctrl.rf_wr_en = 1'b1;
                end
                op_auipc: begin
                    ctrl.src_1_pc  = 1'b1;
                    ctrl.src_2_imm = 1'b1;
                    ctrl.imm_type  = imm_u;
                    ctrl.rf_wr_en  = 1'b1;
                end
                default: begin
                    ctrl.rf_wr_en = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== src/rv_core.sv ====
module rv_core (
    input  logic         clk,
    input  logic         reset,
    input  rv_pkg::word_t instr,
    input  rv_pkg::word_t rd_data,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t addr,
    output rv_pkg::word_t wr_data,
    output logic [3:0]   wr_en
);
    import rv_pkg::*;

    ctrl_t ctrl;
    word_t imm;
    word_t pc_plus_4;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t load_data;
    word_t wb_data;
    logic  cmp_flag;

    rv_decoder u_decoder (
        .reset    (reset),
        .instr    (instr),
        .cmp_flag (cmp_flag),
        .ctrl     (ctrl)
    );

    rv_imm_gen u_imm_gen (
        .instr    (instr),
        .imm_type (ctrl.imm_type),
        .imm      (imm)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .rd       (instr[11:7]),
        .wr_en    (ctrl.rf_wr_en),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // operand selection
    assign alu_a = ctrl.src_1_pc ? pc : rs1_data;
    assign alu_b = ctrl.src_2_imm ? imm : rs2_data;

    rv_alu u_alu (
        .op       (ctrl.alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_result),
        .cmp_flag (cmp_flag)
    );

    rv_lsu u_lsu (
        .ctrl      (ctrl),
        .rd_data   (rd_data),
        .load_data (load_data),
        .wr_en     (wr_en)
    );

    rv_fetch u_fetch (
        .clk        (clk),
        .reset      (reset),
        .pc_sel     (ctrl.pc_sel),
        .imm        (imm),
        .alu_result (alu_result),
        .pc         (pc),
        .pc_plus_4  (pc_plus_4)
    );

    // write-back source
    always_comb begin
        case (ctrl.wb_sel)
            wb_load:      wb_data = load_data;
            wb_pc_plus_4: wb_data = pc_plus_4;
            wb_imm:       wb_data = imm;
            default:      wb_data = alu_result;
        endcase
    end

    assign addr    = alu_result;
    assign wr_data = rs2_data;

endmodule

// ==== dv/rv_core_props.sv ====
module rv_core_props (
    input logic          clk,
    input logic          reset,
    input rv_pkg::word_t pc,
    input rv_pkg::word_t addr,
    input logic [3:0]    wr_en
);

    // no store may leave the core during reset
    reset_no_store: assert property (@(posedge clk) reset |-> wr_en == 4'b0000)
        else $error("wr_en set while reset is high");

    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    // byte, half and word masks only, each on its own boundary
    store_mask_legal: assert property (@(posedge clk)
        (wr_en == 4'b0000) || (wr_en == 4'b0001) ||
        (wr_en == 4'b0011 && addr[0] == 1'b0) ||
        (wr_en == 4'b1111 && addr[1:0] == 2'b00))
        else $error("wr_en holds an unexpected mask or the store is misaligned");

endmodule

bind rv_core rv_core_props props (
    .clk   (clk),
    .reset (reset),
    .pc    (pc),
    .addr  (addr),
    .wr_en (wr_en)
);

// ==== dv/tb_rv_core.sv ====
module tb_rv_core;
    import rv_pkg::*;

    localparam int prog_len   = 200;
    localparam int rand_start = 62;
    localparam int rand_end   = 190;
    localparam int run_cycles = 300;
    // twice the program length, well past the 300 retired cycles
    localparam int max_cycles = 2 * prog_len;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    word_t       instr;
    word_t       rd_data;
    word_t       pc;
    word_t       addr;
    word_t       wr_data;
    logic [3:0]  wr_en;

    word_t       prog [256];
    word_t       dmem [64];
    word_t       model_mem [64];
    word_t       model_regs [32];
    word_t       model_pc;
    logic [31:0] rng_state;
    int          retired = 0;
    int          cycles = 0;

    rv_core dut (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .rd_data (rd_data),
        .pc      (pc),
        .addr    (addr),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

    // both memories answer within the cycle
    assign instr   = prog[pc[9:2]];
    assign rd_data = dmem[addr[7:2]];

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = xorshift32(rng_state);
        return rng_state % n;
    endfunction

    // x1 and x2 hold fixed bases and are never destinations
    function automatic logic [4:0] pick_rd();
        logic [4:0] r;
        r = 5'(rand_below(32));
        return (r == 5'd1 || r == 5'd2) ? 5'd0 : r;
    endfunction

    function automatic word_t r_format(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_format(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_format(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_format(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t j_format(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                          input logic [3:0] mask);
        word_t w;
        w = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) begin
                w[8*lane +: 8] = new_word[8*lane +: 8];
            end
        end
        return w;
    endfunction

    task automatic build_program();
        int          idx;
        int unsigned kind;
        int unsigned sel;
        logic [2:0]  f3;
        logic [4:0]  rs_a;
        logic [4:0]  rs_b;
        logic [11:0] off;
        // every register gets a lui/addi pair, x1 becomes 0x100
        for (int r = 1; r < 32; r++) begin
            if (r == 1) begin
                prog[0] = u_format(20'h0, 5'd1, 7'b0110111);
                prog[1] = i_format(12'h100, 5'd1, 3'b000, 5'd1, 7'b0010011);
            end else if (r == 2) begin
                // x2 starts at the padding so an early jalr lands there
                prog[2] = u_format(20'h0, 5'd2, 7'b0110111);
                prog[3] = i_format(12'(4 * rand_end), 5'd2, 3'b000, 5'd2, 7'b0010011);
            end else begin
                prog[2*r-2] = u_format(20'(rand_below(32'h10_0000)), 5'(r), 7'b0110111);
                prog[2*r-1] = i_format(12'(rand_below(4096)), 5'(r), 3'b000, 5'(r),
                                       7'b0010011);
            end
        end
        idx = rand_start;
        while (idx < rand_end) begin
            kind = rand_below(100);
            f3   = 3'(rand_below(8));
            rs_a = 5'(rand_below(32));
            rs_b = 5'(rand_below(32));
            off  = 12'(rand_below(64) * 4);
            if (kind < 5) begin
                // custom opcode, store width 3 or funct7 of 1
                sel = rand_below(3);
                if (sel == 0) begin
                    prog[idx] = {rng_state[31:7], 7'b0001011};
                end else if (sel == 1) begin
                    prog[idx] = s_format(off, rs_b, 5'd1, 3'b011);
                end else begin
                    prog[idx] = r_format(7'h01, rs_b, rs_a, f3, pick_rd());
                end
            end else if (kind < 25) begin
                prog[idx] = i_format((f3[1:0] == 2'b01) ?
                                     {1'b0, f3[2] & rng_state[0], 5'b0, rs_b} :
                                     12'(rand_below(4096)),
                                     rs_a, f3, pick_rd(), 7'b0010011);
            end else if (kind < 40) begin
                prog[idx] = r_format(((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ?
                                     7'h20 : 7'h00, rs_b, rs_a, f3, pick_rd());
            end else if (kind < 55) begin
                sel = rand_below(5);
                prog[idx] = i_format(off, 5'd1, 3'((sel > 2) ? sel + 1 : sel), pick_rd(),
                                     7'b0000011);
            end else if (kind < 70) begin
                prog[idx] = s_format(off, (rand_below(4) == 0) ? 5'd0 : rs_b, 5'd1,
                                     3'(rand_below(3)));
            end else if (kind < 80) begin
                sel = rand_below(6);
                prog[idx] = b_format(13'((1 + rand_below(4)) * 4), rs_b, rs_a,
                                     3'((sel < 2) ? sel : sel + 2));
            end else if (kind < 85 && idx + 1 < rand_end) begin
                // auipc sets the base, jalr lands a few words on, odd offsets too
                prog[idx] = u_format(20'h0, 5'd2, 7'b0010111);
                idx = idx + 1;
                prog[idx] = i_format(12'((2 + rand_below(3)) * 4 + rand_below(2)), 5'd2,
                                     3'b000, pick_rd(), 7'b1100111);
            end else if (kind < 90) begin
                prog[idx] = j_format(21'((1 + rand_below(4)) * 4), pick_rd());
            end else begin
                prog[idx] = u_format(20'(rand_below(32'h10_0000)), pick_rd(),
                                     (rand_below(2) == 1) ? 7'b0110111 : 7'b0010111);
            end
            idx = idx + 1;
        end
        for (int i = rand_end; i < prog_len - 1; i++) begin
            prog[i] = i_format(12'h0, 5'd0, 3'b000, 5'd0, 7'b0010011);
        end
        // jal-to-self at the end and beyond
        for (int i = prog_len - 1; i < 256; i++) begin
            prog[i] = j_format(21'h0, 5'd0);
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]      = rand_below(32'hffff_ffff);
            model_mem[i] = dmem[i];
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction of the ISA model, checked against the DUT first
    task automatic model_step();
        word_t      ins, rs1v, rs2v, a, wv, npc, word;
        word_t      imm_i, imm_s, imm_b, imm_j, imm_u;
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [4:0] rd;
        logic       legal;
        logic       wr;
        logic       taken;
        logic [3:0] mask;
        ins   = prog[model_pc[9:2]];
        op    = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        rs1v  = model_regs[ins[19:15]];
        rs2v  = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        legal = 1'b1;
        wr    = 1'b0;
        wv    = '0;
        mask  = 4'b0000;
        a     = rs1v + imm_i;
        npc   = model_pc + 32'd4;
        check_value("pc", model_pc, pc);
        case (op)
            7'b0110111: begin
                wr = 1'b1;
                wv = imm_u;
            end
            7'b0010111: begin
                wr = 1'b1;
                wv = model_pc + imm_u;
            end
            7'b1101111: begin
                wr  = 1'b1;
                wv  = model_pc + 32'd4;
                npc = model_pc + imm_j;
            end
            7'b1100111: begin
                legal = (f3 == 3'd0);
                wr    = 1'b1;
                wv    = model_pc + 32'd4;
                npc   = {a[31:1], 1'b0};
            end
            7'b1100011: begin
                legal = (f3[2:1] != 2'b01);
                case (f3)
                    3'd0:    taken = (rs1v == rs2v);
                    3'd1:    taken = (rs1v != rs2v);
                    3'd4:    taken = ($signed(rs1v) < $signed(rs2v));
                    3'd5:    taken = ($signed(rs1v) >= $signed(rs2v));
                    3'd6:    taken = (rs1v < rs2v);
                    default: taken = (rs1v >= rs2v);
                endcase
                if (taken) begin
                    npc = model_pc + imm_b;
                end
            end
            7'b0000011: begin
                legal = (f3 != 3'd3 && f3[2:1] != 2'b11);
                wr    = 1'b1;
                word  = model_mem[a[7:2]];
                case (f3)
                    3'd0:    wv = {{24{word[7]}}, word[7:0]};
                    3'd1:    wv = {{16{word[15]}}, word[15:0]};
                    3'd4:    wv = {24'b0, word[7:0]};
                    3'd5:    wv = {16'b0, word[15:0]};
                    default: wv = word;
                endcase
            end
            7'b0100011: begin
                legal = (f3 < 3'd3);
                a     = rs1v + imm_s;
                mask  = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
            end
            7'b0010011: begin
                legal = (f3 != 3'd1 || f7 == 7'h00) &&
                        (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
                wr    = 1'b1;
                wv    = model_alu(f3, f3 == 3'd5 && f7[5], rs1v, imm_i);
            end
            7'b0110011: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                wr    = 1'b1;
                wv    = model_alu(f3, f7[5], rs1v, rs2v);
            end
            default: legal = 1'b0;
        endcase
        // illegal words retire as no-ops
        if (!legal) begin
            wr   = 1'b0;
            mask = 4'b0000;
            npc  = model_pc + 32'd4;
        end
        check_value("wr_en", word_t'(mask), word_t'(wr_en));
        if (mask != 4'b0000) begin
            check_value("addr", a, addr);
            check_value("wr_data", rs2v, wr_data);
            model_mem[a[7:2]] = merge_lanes(model_mem[a[7:2]], rs2v, mask);
        end
        if (wr && rd != 5'd0) begin
            model_regs[rd] = wv;
        end
        model_pc = npc;
    endtask

    always @(posedge clk) begin
        if (wr_en != 4'b0000) begin
            dmem[addr[7:2]] <= merge_lanes(dmem[addr[7:2]], wr_data, wr_en);
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (reset) begin
            check_value("wr_en", '0, word_t'(wr_en));
            check_value("pc", '0, pc);
        end else begin
            if (retired == 1) begin
                check_value("pc", 32'h4, pc);
            end
            model_step();
            retired = retired + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rng_state = 32'd99827;
        model_pc  = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        while (retired < run_cycles) begin
            @(posedge clk);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/rv_pkg.sv
src/rv_alu.sv
src/rv_imm_gen.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_lsu.sv
src/rv_decoder.sv
src/rv_core.sv
dv/rv_core_props.sv
dv/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
